// File: Makefile
# Verilator lint, simulation and clean targets for the register hub

VERILATOR ?= verilator
FILELIST  ?= sim.f
TOP       ?= qla_reg_hub_tb
RTL_TOP   ?= qla_reg_hub
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: logic/axis_regs.sv
// per-axis dac command registers and command / feedback readback
`timescale 1ns/1ns

module axis_regs #(
    parameter int NUM_AXES = 4
) (
    input  logic           sysclk,
    input  logic           rst_n,
    input  logic           reg_wen,
    input  qla_pkg::addr_t reg_waddr,
    input  qla_pkg::data_t reg_wdata,
    input  qla_pkg::addr_t reg_raddr,
    input  qla_pkg::cmd_t  cur_fb  [1:NUM_AXES],   // current feedback per axis
    output qla_pkg::cmd_t  cur_cmd [1:NUM_AXES],   // parallel dac words
    output qla_pkg::data_t axis_rdata
);
    import qla_pkg::*;

    logic dac_wsel;     // write aimed at some axis dac register

    assign dac_wsel = reg_wen && (reg_waddr.space == ADDR_MAIN)
                      && (reg_waddr.offset == OFF_DAC_CTRL);

    // ----------------------------------------
    // dac commands, idle at zero current
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i <= NUM_AXES; i++)
                cur_cmd[i] <= CMD_MID;
        end else if (dac_wsel) begin
            for (int i = 1; i <= NUM_AXES; i++) begin
                if (reg_waddr.chan == CHAN_W'(i))
                    cur_cmd[i] <= reg_wdata[CMD_W-1:0];   // low half only
            end
        end
    end

    // readback, zero extended
    always_comb begin
        axis_rdata = '0;
        for (int i = 1; i <= NUM_AXES; i++) begin
            if (reg_raddr.chan == CHAN_W'(i)) begin
                if (reg_raddr.offset == OFF_DAC_CTRL)
                    axis_rdata = {{(DATA_W - CMD_W){1'b0}}, cur_cmd[i]};
                else if (reg_raddr.offset == OFF_ADC_DATA)
                    axis_rdata = {{(DATA_W - CMD_W){1'b0}}, cur_fb[i]};
            end
        end
    end

endmodule

// File: logic/board_regs.sv
// channel 0 status register, power and amplifier enables with command pulses
`timescale 1ns/1ns

module board_regs #(
    parameter int NUM_AXES = 4
) (
    input  logic                      sysclk,
    input  logic                      rst_n,
    input  logic                      reg_wen,
    input  qla_pkg::addr_t            reg_waddr,
    input  qla_pkg::data_t            reg_wdata,
    input  logic [qla_pkg::BID_W-1:0] board_id,
    input  logic [NUM_AXES:1]         safety_disable,
    output qla_pkg::data_t            board_rdata,
    output logic                      pwr_enable,
    output logic [NUM_AXES:1]         amp_enable,
    output logic                      pwr_enable_cmd,   // one cycle after enabling write
    output logic [NUM_AXES:1]         amp_enable_cmd
);
    import qla_pkg::*;

    logic              status_wen;
    logic              pwr_next;
    logic [NUM_AXES:1] amp_q;           // requested enables, gated by power
    logic [NUM_AXES:1] amp_next;
    logic [NUM_AXES:1] amp_cmd_next;

    assign status_wen = reg_wen && (reg_waddr.space == ADDR_MAIN) && (reg_waddr.zero == '0)
                        && (reg_waddr.chan == '0) && (reg_waddr.offset == REG_STATUS);

    assign pwr_next = (status_wen && reg_wdata[ST_PWR_MASK]) ? reg_wdata[ST_PWR] : pwr_enable;

    // ----------------------------------------
    // amp enable update
    // ----------------------------------------
    always_comb begin
        for (int i = 1; i <= NUM_AXES; i++) begin
            if (status_wen && reg_wdata[ST_DIS_LSB + i - 1]) begin   // masked write
                amp_next[i]     = reg_wdata[ST_AMP_LSB + i - 1];
                amp_cmd_next[i] = reg_wdata[ST_AMP_LSB + i - 1];
            end else begin
                // tripped axis drops, except while its clear pulse is out
                amp_next[i]     = amp_q[i] & ~(safety_disable[i] & ~amp_enable_cmd[i]
                                               & ~pwr_enable_cmd);
                amp_cmd_next[i] = 1'b0;
            end
        end
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            pwr_enable     <= 1'b0;
            amp_q          <= '0;
            pwr_enable_cmd <= 1'b0;
            amp_enable_cmd <= '0;
        end else begin
            pwr_enable     <= pwr_next;
            amp_q          <= amp_next & {NUM_AXES{pwr_next}};   // no power, no amps
            pwr_enable_cmd <= status_wen & reg_wdata[ST_PWR_MASK] & reg_wdata[ST_PWR];
            amp_enable_cmd <= amp_cmd_next;
        end
    end

    assign amp_enable = amp_q & ~safety_disable;   // disable takes effect at once

    // status readback
    always_comb begin
        board_rdata                           = '0;
        board_rdata[ST_AMP_LSB +: NUM_AXES]   = amp_enable;
        board_rdata[ST_DIS_LSB +: NUM_AXES]   = safety_disable;
        board_rdata[ST_PWR]                   = pwr_enable;
        board_rdata[ST_BID_LSB +: BID_W]      = board_id;
    end

endmodule

// File: logic/bus_arbiter.sv
// write bus master select, real-time source select, read address select and read decode
`timescale 1ns/1ns

module bus_arbiter #(
    parameter int NUM_AXES = 4
) (
    // firewire
    input  logic           fw_reg_wen,
    input  qla_pkg::addr_t fw_reg_waddr,
    input  qla_pkg::data_t fw_reg_wdata,
    input  qla_pkg::addr_t fw_reg_raddr,
    input  logic           fw_rt_wen,
    input  logic [2:0]     fw_rt_waddr,
    input  qla_pkg::data_t fw_rt_wdata,
    // ethernet
    input  logic           eth_write_en,     // eth owns write bus
    input  logic           eth_reg_wen,
    input  qla_pkg::addr_t eth_reg_waddr,
    input  qla_pkg::data_t eth_reg_wdata,
    input  logic           eth_read_en,      // eth owns read address
    input  qla_pkg::addr_t eth_reg_raddr,
    input  logic           eth_rt_wen,
    input  logic [2:0]     eth_rt_waddr,
    input  qla_pkg::data_t eth_rt_wdata,
    // real-time block writer
    input  logic           bw_write_en,
    input  logic           bw_reg_wen,
    input  qla_pkg::addr_t bw_reg_waddr,
    input  qla_pkg::data_t bw_reg_wdata,
    // read data sources
    input  qla_pkg::data_t board_rdata,
    input  qla_pkg::data_t axis_rdata,
    // shared bus
    output logic           reg_wen,
    output qla_pkg::addr_t reg_waddr,
    output qla_pkg::data_t reg_wdata,
    output qla_pkg::addr_t reg_raddr,
    output qla_pkg::data_t reg_rdata,
    output logic           rt_wen,
    output logic [2:0]     rt_waddr,
    output qla_pkg::data_t rt_wdata
);
    import qla_pkg::*;

    // ----------------------------------------
    // write bus, block writer > eth > fw
    // ----------------------------------------
    always_comb begin
        if (bw_write_en) begin
            reg_wen   = bw_reg_wen;
            reg_waddr = bw_reg_waddr;
            reg_wdata = bw_reg_wdata;
        end else if (eth_write_en) begin
            reg_wen   = eth_reg_wen;
            reg_waddr = eth_reg_waddr;
            reg_wdata = eth_reg_wdata;
        end else begin              // firewire by default
            reg_wen   = fw_reg_wen;
            reg_waddr = fw_reg_waddr;
            reg_wdata = fw_reg_wdata;
        end
    end

    // real-time source, eth wins while strobing
    assign rt_wen   = eth_rt_wen ? 1'b1 : fw_rt_wen;
    assign rt_waddr = eth_rt_wen ? eth_rt_waddr : fw_rt_waddr;
    assign rt_wdata = eth_rt_wen ? eth_rt_wdata : fw_rt_wdata;

    // ----------------------------------------
    // read path
    // ----------------------------------------
    assign reg_raddr = eth_read_en ? eth_reg_raddr : fw_reg_raddr;

    always_comb begin
        if (reg_raddr.space != ADDR_MAIN)
            reg_rdata = '0;                          // other spaces not populated
        else if (reg_raddr.chan == '0)
            reg_rdata = board_rdata;                 // channel 0, board regs
        else if (reg_raddr.chan <= CHAN_W'(NUM_AXES))
            reg_rdata = axis_rdata;
        else
            reg_rdata = '0;                          // no such axis
    end

endmodule

// File: logic/qla_pkg.sv
// register bus widths, address fields, space code, channel offsets and status bits
package qla_pkg;

    // ----------------------------------------
    // bus widths
    // ----------------------------------------
    localparam int ADDR_W  = 16;        // register address
    localparam int DATA_W  = 32;        // register data
    localparam int CMD_W   = 16;        // dac command / current feedback
    localparam int SPACE_W = 4;         // addr[15:12]
    localparam int ZERO_W  = 4;         // addr[11:8], always zero
    localparam int CHAN_W  = 4;         // addr[7:4]
    localparam int OFF_W   = 4;         // addr[3:0]
    localparam int BID_W   = 4;         // rotary switch board id

    typedef struct packed {
        logic [SPACE_W-1:0] space;      // address space
        logic [ZERO_W-1:0]  zero;
        logic [CHAN_W-1:0]  chan;       // 0 = board, 1..N = axis
        logic [OFF_W-1:0]   offset;     // register within channel
    } addr_t;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [CMD_W-1:0]  cmd_t;   // offset binary, mid-scale = zero current

    localparam logic [SPACE_W-1:0] ADDR_MAIN    = 4'h0;
    localparam logic [OFF_W-1:0]   REG_STATUS   = 4'h0;   // channel 0
    localparam logic [OFF_W-1:0]   OFF_ADC_DATA = 4'h0;   // per axis, feedback
    localparam logic [OFF_W-1:0]   OFF_DAC_CTRL = 4'h1;   // per axis, command
    localparam cmd_t               CMD_MID      = 16'h8000;

    // status register bit positions
    localparam int ST_AMP_LSB  = 0;     // amp enable value
    localparam int ST_DIS_LSB  = 8;     // amp mask on write, safety disable on read
    localparam int ST_PWR      = 16;    // power enable value
    localparam int ST_PWR_MASK = 17;    // power mask on write
    localparam int ST_BID_LSB  = 24;    // board id on read

endpackage

// File: logic/qla_reg_hub.sv
// register bus top: arbiter, real-time block writer, axis and board regs, safety checks
`timescale 1ns/1ns

module qla_reg_hub #(
    parameter int            NUM_AXES      = 4,
    parameter int            SAFETY_COUNT  = 8,
    parameter qla_pkg::cmd_t SAFETY_MARGIN = 16'd256
) (
    input  logic                      sysclk,
    input  logic                      rst_n,
    // firewire host
    input  logic                      fw_reg_wen,
    input  qla_pkg::addr_t            fw_reg_waddr,
    input  qla_pkg::data_t            fw_reg_wdata,
    input  qla_pkg::addr_t            fw_reg_raddr,
    input  logic                      fw_rt_wen,
    input  logic [2:0]                fw_rt_waddr,
    input  qla_pkg::data_t            fw_rt_wdata,
    // ethernet host
    input  logic                      eth_write_en,
    input  logic                      eth_reg_wen,
    input  qla_pkg::addr_t            eth_reg_waddr,
    input  qla_pkg::data_t            eth_reg_wdata,
    input  logic                      eth_read_en,
    input  qla_pkg::addr_t            eth_reg_raddr,
    input  logic                      eth_rt_wen,
    input  logic [2:0]                eth_rt_waddr,
    input  qla_pkg::data_t            eth_rt_wdata,
    // board
    input  logic [qla_pkg::BID_W-1:0] board_id,
    input  qla_pkg::cmd_t             cur_fb [1:NUM_AXES],
    output qla_pkg::data_t            reg_rdata,
    output qla_pkg::cmd_t             cur_cmd [1:NUM_AXES],
    output logic                      pwr_enable,
    output logic [NUM_AXES:1]         amp_enable
);
    import qla_pkg::*;

    // shared write / read bus
    logic              reg_wen;
    addr_t             reg_waddr;
    data_t             reg_wdata;
    addr_t             reg_raddr;
    // real-time path
    logic              rt_wen;
    logic [2:0]        rt_waddr;
    data_t             rt_wdata;
    logic              bw_write_en;
    logic              bw_reg_wen;
    addr_t             bw_reg_waddr;
    data_t             bw_reg_wdata;
    // read sources and safety
    data_t             board_rdata;
    data_t             axis_rdata;
    logic [NUM_AXES:1] safety_disable;
    logic              pwr_enable_cmd;
    logic [NUM_AXES:1] amp_enable_cmd;
    wire  [NUM_AXES:1] safety_clear;    // re-enable clears the latched trip

    // ----------------------------------------
    // bus modules
    // ----------------------------------------
    bus_arbiter #(.NUM_AXES(NUM_AXES)) arbiter (.*);

    rt_block_writer #(.NUM_AXES(NUM_AXES)) rt_write (.*);

    axis_regs #(.NUM_AXES(NUM_AXES)) axes (.*);

    board_regs #(.NUM_AXES(NUM_AXES)) chan0 (.*);

    // ----------------------------------------
    // one safety check per axis
    // ----------------------------------------
    for (genvar i = 1; i <= NUM_AXES; i++) begin : g_safe
        assign safety_clear[i] = pwr_enable_cmd | amp_enable_cmd[i];

        safety_check #(
            .SAFETY_COUNT  (SAFETY_COUNT),
            .SAFETY_MARGIN (SAFETY_MARGIN)
        ) safe (
            .sysclk        (sysclk),
            .rst_n         (rst_n),
            .cur_in        (cur_fb[i]),
            .dac_in        (cur_cmd[i]),
            .clear_disable (safety_clear[i]),
            .amp_disable   (safety_disable[i])
        );
    end

endmodule

// File: logic/rt_block_writer.sv
// real-time axis command buffer and replay onto the register write bus
`timescale 1ns/1ns

module rt_block_writer #(
    parameter int NUM_AXES = 4
) (
    input  logic           sysclk,
    input  logic           rst_n,
    input  logic           rt_wen,
    input  logic [2:0]     rt_waddr,        // 0..N-1 axis word, N control word
    input  qla_pkg::data_t rt_wdata,
    output logic           bw_write_en,     // owns write bus during replay
    output logic           bw_reg_wen,
    output qla_pkg::addr_t bw_reg_waddr,
    output qla_pkg::data_t bw_reg_wdata
);
    import qla_pkg::*;

    localparam int CNT_W = $clog2(NUM_AXES + 1);

    cmd_t             cmd_buf [NUM_AXES];   // one command per axis
    data_t            ctrl_word;            // goes to status reg last
    logic             busy;                 // replay in progress
    logic [CNT_W-1:0] step;                 // replay slot, N = status write
    logic             buf_wen;
    logic             start;

    assign buf_wen = rt_wen & ~busy;        // dropped while replaying
    assign start   = buf_wen && (rt_waddr == 3'(NUM_AXES));

    // ----------------------------------------
    // command buffer
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (buf_wen) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                if (rt_waddr == 3'(i))
                    cmd_buf[i] <= rt_wdata[CMD_W-1:0];
            end
            if (start)
                ctrl_word <= rt_wdata;
        end
    end

    // replay sequencer, N axis writes then one status write
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            step <= '0;
        end else if (start) begin
            busy <= 1'b1;
            step <= '0;
        end else if (busy) begin
            if (step == CNT_W'(NUM_AXES))
                busy <= 1'b0;               // status word just went out
            step <= step + CNT_W'(1);
        end
    end

    // ----------------------------------------
    // replay address and data
    // ----------------------------------------
    always_comb begin
        bw_reg_waddr.space  = ADDR_MAIN;
        bw_reg_waddr.zero   = '0;
        bw_reg_waddr.chan   = '0;           // status reg unless an axis slot
        bw_reg_waddr.offset = REG_STATUS;
        bw_reg_wdata        = ctrl_word;
        for (int i = 0; i < NUM_AXES; i++) begin
            if (step == CNT_W'(i)) begin
                bw_reg_waddr.chan   = CHAN_W'(i + 1);
                bw_reg_waddr.offset = OFF_DAC_CTRL;
                bw_reg_wdata        = {{(DATA_W - CMD_W){1'b0}}, cmd_buf[i]};
            end
        end
    end

    assign bw_write_en = busy;
    assign bw_reg_wen  = busy;              // one write per replay cycle

endmodule

// File: logic/safety_check.sv
// per-axis overcurrent detector with latched amplifier disable
`timescale 1ns/1ns

module safety_check #(
    parameter int            SAFETY_COUNT  = 8,        // consecutive samples to trip
    parameter qla_pkg::cmd_t SAFETY_MARGIN = 16'd256
) (
    input  logic          sysclk,
    input  logic          rst_n,
    input  qla_pkg::cmd_t cur_in,          // measured current
    input  qla_pkg::cmd_t dac_in,          // commanded current
    input  logic          clear_disable,
    output logic          amp_disable      // latched until cleared
);
    import qla_pkg::*;

    localparam int CNT_W = $clog2(SAFETY_COUNT + 1);
    localparam int LIM_W = CMD_W + 2;      // 2x magnitude plus margin

    cmd_t             cur_mag;
    cmd_t             dac_mag;
    logic [LIM_W-1:0] limit;
    logic             over;
    logic [CNT_W-1:0] over_cnt;            // over-limit samples so far

    // magnitudes about mid-scale
    assign cur_mag = (cur_in >= CMD_MID) ? cur_in - CMD_MID : CMD_MID - cur_in;
    assign dac_mag = (dac_in >= CMD_MID) ? dac_in - CMD_MID : CMD_MID - dac_in;
    assign limit   = {1'b0, dac_mag, 1'b0} + LIM_W'(SAFETY_MARGIN);
    assign over    = LIM_W'(cur_mag) > limit;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            over_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (clear_disable) begin                 // clear beats trip
            over_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (!over) begin
            over_cnt <= '0;
        end else if (over_cnt == CNT_W'(SAFETY_COUNT - 1)) begin
            amp_disable <= 1'b1;                          // count held, stays tripped
        end else begin
            over_cnt <= over_cnt + CNT_W'(1);
        end
    end

endmodule

// File: sim.f
logic/qla_pkg.sv
logic/bus_arbiter.sv
logic/rt_block_writer.sv
logic/axis_regs.sv
logic/board_regs.sv
logic/safety_check.sv
logic/qla_reg_hub.sv
sim/qla_reg_hub_checker.sv
sim/qla_reg_hub_tb.sv

// File: sim/qla_patterns.txt
// columns: opcode  addr_or_axis  data_or_expected   (all hex, one operation per line)
// ops: 1 fw wr, 2 eth wr, 3 eth wr + lost fw wr, 4/5 rt wr fw/eth, 6/7 read fw/eth,
//      8 set cur_fb (0 = noise), 9 cur_cmd port, A {pwr,amp} ports, B wait, C replay, D poll
// after reset
6 0000 0A000000
6 0011 00008000
6 0041 00008000
9 0001 00008000
// host writes, eth owns the bus over fw
1 0011 00007000
2 0021 00009000
3 0031 0000A000
7 0011 00007000
6 0021 00009000
6 0031 0000A000
6 0051 00000000
6 1000 00000000
// real-time block, four axis words then control word
4 0000 00008100
4 0001 00008200
5 0002 00008300
5 0003 00008400
5 0004 00030F0F
C 0000 00000000
6 0011 00008100
6 0041 00008400
6 0000 0A01000F
A 0000 0000001F
9 0004 00008400
// masked status writes
1 0000 00020000
6 0000 0A000000
A 0000 00000000
2 0000 00030000
6 0000 0A010000
1 0000 00000F0F
6 0000 0A01000F
// overcurrent trip on axis 2, then recovery
1 0021 000083E8
8 0002 00008BB8
D 0000 0A01020D
B 000A 00000000
6 0000 0A01020D
6 0020 00008BB8
A 0000 0000001D
8 0002 00000000
1 0000 00000202
D 0000 0A01000F
A 0000 0000001F
0 0000 00000000

// File: sim/qla_reg_hub_checker.sv
// concurrent assertions on power / amp enables and block writer bus ownership
`timescale 1ns/1ns

module qla_reg_hub_checker #(
    parameter int NUM_AXES = 4
) (
    input logic              sysclk,
    input logic              rst_n,
    input logic              pwr_enable,
    input logic [NUM_AXES:1] amp_enable,
    input logic [NUM_AXES:1] safety_disable,
    input logic [NUM_AXES:1] amp_enable_cmd,
    input logic              bw_write_en
);
    int          error_count = 0;       // failed assertions so far
    int unsigned bw_run;                // consecutive cycles block writer held bus

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n)
            bw_run <= 0;
        else
            bw_run <= bw_write_en ? bw_run + 1 : 0;
    end

    // ----------------------------------------
    // properties
    // ----------------------------------------
    amp_needs_pwr: assert property (@(posedge sysclk) disable iff (!rst_n)
        (|amp_enable) |-> pwr_enable)
        else begin
            $error("amplifier enabled while power is off");
            error_count++;
        end

    bw_bounded: assert property (@(posedge sysclk) disable iff (!rst_n)
        bw_write_en |-> (bw_run < NUM_AXES + 1))
        else begin
            $error("block writer held the write bus longer than %0d cycles", NUM_AXES + 1);
            error_count++;
        end

    for (genvar i = 1; i <= NUM_AXES; i++) begin : g_axis
        // a trip drops the stored enable, only a re-enable pulse brings the amp back
        amp_back_on_enable: assert property (@(posedge sysclk) disable iff (!rst_n)
            $fell(safety_disable[i])
            |-> (amp_enable[i] == $past(amp_enable_cmd[i] & pwr_enable)))
            else begin
                $error("axis %0d amplifier state wrong after its trip cleared", i);
                error_count++;
            end
    end

endmodule

bind qla_reg_hub qla_reg_hub_checker #(.NUM_AXES(NUM_AXES)) checks (
    .sysclk         (sysclk),
    .rst_n          (rst_n),
    .pwr_enable     (pwr_enable),
    .amp_enable     (amp_enable),
    .safety_disable (safety_disable),
    .amp_enable_cmd (amp_enable_cmd),
    .bw_write_en    (bw_write_en)
);

// File: sim/qla_reg_hub_tb.sv
// testbench for the register hub, pattern file stimulus with readback and port checks
`timescale 1ns/1ns

module qla_reg_hub_tb;
    import qla_pkg::*;

    localparam int NUM_AXES   = 4;
    localparam int MAX_WORDS  = 768;        // 3 words per pattern line
    localparam int POLL_MAX   = 64;         // cycles before a poll gives up
    localparam int REPLAY_MAX = 16;         // cycles before replay wait gives up

    logic sysclk = 1'b0;
    logic rst_n;
    logic fw_reg_wen, fw_rt_wen;
    addr_t fw_reg_waddr, fw_reg_raddr;
    data_t fw_reg_wdata, fw_rt_wdata;
    logic [2:0] fw_rt_waddr;
    logic eth_write_en, eth_reg_wen, eth_read_en, eth_rt_wen;
    addr_t eth_reg_waddr, eth_reg_raddr;
    data_t eth_reg_wdata, eth_rt_wdata;
    logic [2:0] eth_rt_waddr;
    logic [BID_W-1:0] board_id;
    cmd_t cur_fb [1:NUM_AXES];
    data_t reg_rdata;
    cmd_t cur_cmd [1:NUM_AXES];
    logic pwr_enable;
    logic [NUM_AXES:1] amp_enable;

    data_t words [MAX_WORDS];               // pattern image
    logic [NUM_AXES:1] fb_fixed;            // axis feedback set by pattern, else noise

    always #4 sysclk = ~sysclk;             // 8 ns period

    qla_reg_hub #(
        .NUM_AXES      (NUM_AXES),
        .SAFETY_COUNT  (8),
        .SAFETY_MARGIN (16'd256)
    ) uut (.*);

    // ----------------------------------------
    // failure handling and compares
    // ----------------------------------------
    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cmd(input string name, input cmd_t got, input cmd_t exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic require_axis(input int ax);
        if (ax < 1 || ax > NUM_AXES) begin
            $display("pattern file names axis %0d, which does not exist", ax);
            abort_run();
        end
    endtask

    // bound checker assertions
    always @(negedge sysclk) begin
        if (uut.checks.error_count != 0) begin
            $display("bound checker assertion failed, see the error above");
            abort_run();
        end
    end

    // ----------------------------------------
    // cycle stepping and feedback
    // ----------------------------------------
    task automatic refresh_feedback();
        for (int i = 1; i <= NUM_AXES; i++) begin
            if (!fb_fixed[i])
                cur_fb[i] = CMD_MID + cmd_t'($urandom % 33) - cmd_t'(16);   // +-16 counts
        end
    endtask

    task automatic next_cycle();
        @(posedge sysclk);
        #1;                                 // drive just after the edge
        refresh_feedback();
    endtask

    task automatic set_feedback(input int ax, input cmd_t value);
        require_axis(ax);
        fb_fixed[ax] = (value != '0);       // zero hands the axis back to noise
        cur_fb[ax]   = value;
        refresh_feedback();
    endtask

    task automatic wait_cycles(input int n);
        for (int k = 0; k < n; k++)
            next_cycle();
    endtask

    // block writer owns the bus until its replay ends
    task automatic wait_replay();
        int n;
        n = 0;
        while (uut.bw_write_en) begin
            if (n >= REPLAY_MAX) begin
                $display("block writer replay did not finish within %0d cycles", REPLAY_MAX);
                abort_run();
            end
            n++;
            next_cycle();
        end
    endtask

    // ----------------------------------------
    // bus operations
    // ----------------------------------------
    task automatic fw_write(input addr_t a, input data_t d);
        fw_reg_wen   = 1'b1;
        fw_reg_waddr = a;
        fw_reg_wdata = d;
        next_cycle();                       // write lands on this edge
        fw_reg_wen   = 1'b0;
    endtask

    task automatic eth_write(input addr_t a, input data_t d, input logic collide);
        eth_write_en  = 1'b1;
        eth_reg_wen   = 1'b1;
        eth_reg_waddr = a;
        eth_reg_wdata = d;
        if (collide) begin                  // fw hits same reg, must be lost
            fw_reg_wen   = 1'b1;
            fw_reg_waddr = a;
            fw_reg_wdata = ~d;
        end
        next_cycle();
        eth_write_en = 1'b0;
        eth_reg_wen  = 1'b0;
        fw_reg_wen   = 1'b0;
    endtask

    task automatic rt_write(input logic [2:0] slot, input data_t d, input logic use_eth);
        if (use_eth) begin
            eth_rt_wen   = 1'b1;
            eth_rt_waddr = slot;
            eth_rt_wdata = d;
        end else begin
            fw_rt_wen   = 1'b1;
            fw_rt_waddr = slot;
            fw_rt_wdata = d;
        end
        next_cycle();
        eth_rt_wen = 1'b0;
        fw_rt_wen  = 1'b0;
    endtask

    task automatic read_check(input addr_t a, input data_t exp, input logic use_eth);
        int ax;
        eth_read_en = use_eth;
        if (use_eth)
            eth_reg_raddr = a;
        else
            fw_reg_raddr = a;
        @(negedge sysclk);                  // mid-cycle, read data settled
        if (use_eth)
            check_data("reg_rdata (eth)", reg_rdata, exp);
        else
            check_data("reg_rdata (fw)", reg_rdata, exp);
        ax = int'(a.chan);
        // a dac readback also shows on the parallel command port
        if (a.space == ADDR_MAIN && a.offset == OFF_DAC_CTRL && ax >= 1 && ax <= NUM_AXES)
            check_cmd($sformatf("cur_cmd[%0d]", ax), cur_cmd[ax], cmd_t'(exp[15:0]));
        next_cycle();
        eth_read_en = 1'b0;
    endtask

    task automatic poll_read(input addr_t a, input data_t exp);
        int n;
        n = 0;
        fw_reg_raddr = a;
        @(negedge sysclk);
        while (reg_rdata !== exp) begin
            if (n >= POLL_MAX) begin
                $display("register %h never read %h within %0d cycles", a, exp, POLL_MAX);
                abort_run();
            end
            n++;
            next_cycle();
            @(negedge sysclk);
        end
        next_cycle();
    endtask

    // ----------------------------------------
    // pattern interpreter
    // ----------------------------------------
    initial begin
        int pc;
        logic [3:0] op;
        data_t arg_a;
        data_t arg_d;
        logic done;
        void'($urandom(32'h69d9));
        rst_n = 1'b0;
        {fw_reg_wen, fw_rt_wen, eth_write_en, eth_reg_wen, eth_read_en, eth_rt_wen} = '0;
        {fw_reg_waddr, fw_reg_raddr, eth_reg_waddr, eth_reg_raddr} = '0;
        {fw_reg_wdata, fw_rt_wdata, eth_reg_wdata, eth_rt_wdata} = '0;
        fw_rt_waddr  = '0;
        eth_rt_waddr = '0;
        board_id     = 4'hA;
        fb_fixed     = '0;
        for (int i = 1; i <= NUM_AXES; i++)
            cur_fb[i] = CMD_MID;
        for (int i = 0; i < MAX_WORDS; i++)
            words[i] = '1;                  // unloaded marker
        $readmemh("sim/qla_patterns.txt", words);
        if (words[0] == '1) begin
            $display("pattern file sim/qla_patterns.txt is missing or empty");
            abort_run();
        end
        wait_cycles(5);                     // reset held 5 cycles
        rst_n = 1'b1;
        pc   = 0;
        done = 1'b0;
        while (!done) begin
            if (pc + 2 >= MAX_WORDS) begin
                $display("pattern file runs past %0d words without an end op", MAX_WORDS);
                abort_run();
            end
            op    = words[pc][3:0];
            arg_a = words[pc + 1];
            arg_d = words[pc + 2];
            pc    = pc + 3;
            case (op)
                4'h0: done = 1'b1;
                4'h1: fw_write(addr_t'(arg_a[15:0]), arg_d);
                4'h2: eth_write(addr_t'(arg_a[15:0]), arg_d, 1'b0);
                4'h3: eth_write(addr_t'(arg_a[15:0]), arg_d, 1'b1);
                4'h4: rt_write(arg_a[2:0], arg_d, 1'b0);
                4'h5: rt_write(arg_a[2:0], arg_d, 1'b1);
                4'h6: read_check(addr_t'(arg_a[15:0]), arg_d, 1'b0);
                4'h7: read_check(addr_t'(arg_a[15:0]), arg_d, 1'b1);
                4'h8: set_feedback(int'(arg_a[3:0]), cmd_t'(arg_d[15:0]));
                4'h9: begin
                    require_axis(int'(arg_a[3:0]));
                    check_cmd($sformatf("cur_cmd[%0d]", arg_a[3:0]),
                              cur_cmd[int'(arg_a[3:0])], cmd_t'(arg_d[15:0]));
                end
                4'hA: check_data("{pwr_enable, amp_enable}",
                                 data_t'({pwr_enable, amp_enable}), arg_d);
                4'hB: wait_cycles(int'(arg_a[7:0]));
                4'hC: wait_replay();
                4'hD: poll_read(addr_t'(arg_a[15:0]), arg_d);
                default: begin
                    $display("unknown opcode %h at pattern word %0d", op, pc - 3);
                    abort_run();
                end
            endcase
        end
        if (uut.checks.error_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("bound checker reported %0d assertion failures", uut.checks.error_count);
            abort_run();
        end
    end

endmodule
